// File: include/mem_stage_consts.svh
// widths are fixed for rv64 with an 8-byte data word; changing them needs matching typedef review
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// ********************
// datapath widths
// ********************
`define MEM_XLEN      64   // data and address word
`define MEM_INST_W    32   // instruction word

// byte lanes per data word
`define MEM_LANES     8

// ********************
// instruction fields
// ********************
`define MEM_REG_ID_W  5    // register index width
`define MEM_RD_LSB    7    // rd sits at inst[11:7]

// link value is pc plus one instruction
`define MEM_PC_STEP   4

`endif

// File: design/mem_stage_pkg.sv
// types only; the enum encodings are local to this stage and are not riscv opcodes
`default_nettype none

package mem_stage_pkg;

    `include "mem_stage_consts.svh"

    // ********************
    // vector types
    // ********************
    typedef logic [`MEM_XLEN-1:0]              xlen_t;      // data or address
    typedef logic [`MEM_INST_W-1:0]            inst_t;
    typedef logic [`MEM_REG_ID_W-1:0]          reg_id_t;
    typedef logic [7:0]                        byte_t;
    typedef logic [`MEM_LANES-1:0]             lane_mask_t; // one bit per lane
    typedef logic [$clog2(`MEM_LANES)-1:0]     lane_off_t;  // byte offset in word

    // ********************
    // stage operations
    // ********************
    typedef enum logic [3:0] {
        OP_NONE, OP_ALU, OP_LINK, OP_CSR,       // no memory access
        OP_LB, OP_LH, OP_LW, OP_LD,             // signed loads
        OP_LBU, OP_LHU, OP_LWU,                 // unsigned loads
        OP_SB, OP_SH, OP_SW, OP_SD              // stores
    } mem_op_t;

    // access size, bytes = 1 << size
    typedef enum logic [1:0] {
        SZ_B,
        SZ_H,
        SZ_W,
        SZ_D
    } acc_size_t;

endpackage

`default_nettype wire

// File: design/mem_stage_reg.sv
// holds one item; loads whenever out_ready is high, so a bubble is captured too
`timescale 1ns/1ps
`default_nettype none

module mem_stage_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  mem_stage_pkg::xlen_t  in_pc,
    input  mem_stage_pkg::inst_t  in_inst,
    input  mem_stage_pkg::mem_op_t in_op,
    input  mem_stage_pkg::xlen_t  in_alu,
    input  mem_stage_pkg::xlen_t  in_src2,
    input  logic                  out_ready,
    output logic                  st_valid,
    output mem_stage_pkg::xlen_t  st_pc,
    output mem_stage_pkg::inst_t  st_inst,
    output mem_stage_pkg::mem_op_t st_op,
    output mem_stage_pkg::xlen_t  st_alu,
    output mem_stage_pkg::xlen_t  st_src2
);

    import mem_stage_pkg::*;

    // ********************
    // control part
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            st_valid <= 1'b0;
            st_op    <= OP_NONE;      // no write-back, no access
        end else if (out_ready) begin
            st_valid <= in_valid;
            st_op    <= in_op;
        end
        // out_ready low keeps the item in place
    end

    // ********************
    // payload part
    // ********************
    always_ff @(posedge clk) begin
        if (out_ready) begin
            st_pc   <= in_pc;
            st_inst <= in_inst;
            st_alu  <= in_alu;    // result or effective address
            st_src2 <= in_src2;   // store data or csr old value
        end
    end

endmodule

`default_nettype wire

// File: design/mem_access_ctrl.sv
// memory read is combinational; mem_we is a one-cycle strobe tied to the downstream handshake
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
    input  logic                    st_valid,
    input  mem_stage_pkg::mem_op_t  st_op,
    input  mem_stage_pkg::xlen_t    st_alu,
    input  logic                    out_ready,
    output mem_stage_pkg::acc_size_t acc_size,
    output mem_stage_pkg::lane_off_t acc_off,
    output logic                    acc_signed,
    output logic                    is_load,
    output logic                    mem_re,
    output mem_stage_pkg::xlen_t    mem_raddr,
    output logic                    mem_we,
    output mem_stage_pkg::xlen_t    mem_waddr
);

    import mem_stage_pkg::*;

    logic is_store;

    // ********************
    // op decode
    // ********************
    always_comb begin
        acc_size   = SZ_D;
        acc_signed = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        case (st_op)
            OP_LB:  begin acc_size = SZ_B; acc_signed = 1'b1; is_load = 1'b1; end
            OP_LH:  begin acc_size = SZ_H; acc_signed = 1'b1; is_load = 1'b1; end
            OP_LW:  begin acc_size = SZ_W; acc_signed = 1'b1; is_load = 1'b1; end
            OP_LD:  begin acc_size = SZ_D; acc_signed = 1'b1; is_load = 1'b1; end
            OP_LBU: begin acc_size = SZ_B; is_load = 1'b1; end
            OP_LHU: begin acc_size = SZ_H; is_load = 1'b1; end
            OP_LWU: begin acc_size = SZ_W; is_load = 1'b1; end
            OP_SB:  begin acc_size = SZ_B; is_store = 1'b1; end
            OP_SH:  begin acc_size = SZ_H; is_store = 1'b1; end
            OP_SW:  begin acc_size = SZ_W; is_store = 1'b1; end
            OP_SD:  begin acc_size = SZ_D; is_store = 1'b1; end
            default: ;  // alu, link, csr, none
        endcase
    end

    // byte offset inside the 8-byte word
    assign acc_off = st_alu[$bits(lane_off_t)-1:0];

    // ********************
    // memory port
    // ********************
    assign mem_raddr = is_load  ? st_alu : '0;   // quiet address when idle
    assign mem_waddr = is_store ? st_alu : '0;

    assign mem_re = st_valid && is_load;
    // fires only in the cycle the item leaves, so once per store
    assign mem_we = st_valid && is_store && out_ready;

endmodule

`default_nettype wire

// File: design/mem_byte_lane.sv
// LANE must be below MEM_LANES; mask and data are by size and offset only, so gate with mem_we
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_consts.svh"

module mem_byte_lane #(
    parameter int LANE = 0
) (
    input  mem_stage_pkg::acc_size_t acc_size,
    input  mem_stage_pkg::lane_off_t acc_off,
    input  mem_stage_pkg::xlen_t     store_data,
    input  mem_stage_pkg::xlen_t     read_data,
    output logic                     wmask_bit,
    output mem_stage_pkg::byte_t     wdata_byte,
    output mem_stage_pkg::byte_t     rdata_byte
);

    import mem_stage_pkg::*;

    localparam lane_off_t  LANE_IDX = lane_off_t'(LANE);
    localparam logic [4:0] LANES    = 5'(`MEM_LANES);

    logic [4:0] n_bytes;     // 1, 2, 4 or 8
    logic [4:0] lane_end;    // first lane past the access
    lane_off_t  wr_src;      // src2 byte for this lane
    logic [4:0] rd_pos;      // rdata byte that lands here

    // ********************
    // store placement
    // ********************
    always_comb begin
        n_bytes   = 5'd1 << acc_size;
        lane_end  = 5'(acc_off) + n_bytes;
        wr_src    = LANE_IDX - acc_off;   // wraps, only used when in range
        wmask_bit = (LANE_IDX >= acc_off) && (5'(LANE_IDX) < lane_end);
        wdata_byte = wmask_bit ? store_data[wr_src*8 +: 8] : '0;
    end

    // ********************
    // load extraction
    // ********************
    always_comb begin
        rd_pos = 5'(acc_off) + 5'(LANE_IDX);
        // bytes past lane 7 read as zero
        if (rd_pos < LANES) begin
            rdata_byte = read_data[rd_pos[2:0]*8 +: 8];
        end else begin
            rdata_byte = '0;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_writeback.sv
// load_bytes arrive already aligned to lane 0; bytes above the access size are ignored here
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_consts.svh"

module mem_writeback (
    input  logic                     st_valid,
    input  mem_stage_pkg::xlen_t     st_pc,
    input  mem_stage_pkg::inst_t     st_inst,
    input  mem_stage_pkg::mem_op_t   st_op,
    input  mem_stage_pkg::xlen_t     st_alu,
    input  mem_stage_pkg::xlen_t     st_src2,
    input  mem_stage_pkg::acc_size_t acc_size,
    input  logic                     acc_signed,
    input  mem_stage_pkg::xlen_t     load_bytes,
    output logic                     reg_wr_en,
    output mem_stage_pkg::reg_id_t   reg_wr_id,
    output mem_stage_pkg::xlen_t     reg_wr_value
);

    import mem_stage_pkg::*;

    logic  fill;       // extension bit
    xlen_t load_ext;

    // ********************
    // load extension
    // ********************
    always_comb begin
        case (acc_size)
            SZ_B: begin
                fill     = acc_signed && load_bytes[7];
                load_ext = {{(`MEM_XLEN-8){fill}}, load_bytes[7:0]};
            end
            SZ_H: begin
                fill     = acc_signed && load_bytes[15];
                load_ext = {{(`MEM_XLEN-16){fill}}, load_bytes[15:0]};
            end
            SZ_W: begin
                fill     = acc_signed && load_bytes[31];
                load_ext = {{(`MEM_XLEN-32){fill}}, load_bytes[31:0]};
            end
            default: begin
                fill     = 1'b0;   // full width, nothing to extend
                load_ext = load_bytes;
            end
        endcase
    end

    // ********************
    // result select
    // ********************
    always_comb begin
        case (st_op)
            OP_ALU:  reg_wr_value = st_alu;
            OP_LINK: reg_wr_value = st_pc + xlen_t'(`MEM_PC_STEP);  // return address
            OP_CSR:  reg_wr_value = st_src2;   // old csr value
            OP_LB, OP_LH, OP_LW, OP_LD,
            OP_LBU, OP_LHU, OP_LWU: reg_wr_value = load_ext;
            default: reg_wr_value = '0;   // stores and none
        endcase
    end

    assign reg_wr_en = st_valid && (st_op != OP_NONE) &&
                       !(st_op inside {OP_SB, OP_SH, OP_SW, OP_SD});
    assign reg_wr_id = st_inst[`MEM_RD_LSB +: `MEM_REG_ID_W];   // rd field

endmodule

`default_nettype wire

// File: design/mem_stage_top.sv
// one item in flight, one-cycle latency; memory must answer mem_rdata in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_consts.svh"

module mem_stage_top (
    input  logic                     clk,
    input  logic                     rst,
    // upstream
    input  logic                     in_valid,
    output logic                     in_ready,
    input  mem_stage_pkg::xlen_t     in_pc,
    input  mem_stage_pkg::inst_t     in_inst,
    input  mem_stage_pkg::mem_op_t   in_op,
    input  mem_stage_pkg::xlen_t     in_alu,
    input  mem_stage_pkg::xlen_t     in_src2,
    // downstream
    output logic                     out_valid,
    input  logic                     out_ready,
    output mem_stage_pkg::xlen_t     out_pc,
    output mem_stage_pkg::inst_t     out_inst,
    output logic                     reg_wr_en,
    output mem_stage_pkg::reg_id_t   reg_wr_id,
    output mem_stage_pkg::xlen_t     reg_wr_value,
    // memory
    output logic                     mem_re,
    output mem_stage_pkg::xlen_t     mem_raddr,
    input  mem_stage_pkg::xlen_t     mem_rdata,
    output logic                     mem_we,
    output mem_stage_pkg::xlen_t     mem_waddr,
    output mem_stage_pkg::xlen_t     mem_wdata,
    output mem_stage_pkg::lane_mask_t mem_wmask
);

    import mem_stage_pkg::*;

    localparam int BYTE_W = `MEM_XLEN / `MEM_LANES;

    logic      st_valid;
    xlen_t     st_pc;
    inst_t     st_inst;
    mem_op_t   st_op;
    xlen_t     st_alu;
    xlen_t     st_src2;
    acc_size_t acc_size;
    lane_off_t acc_off;
    logic      acc_signed;
    logic      is_load;
    xlen_t     lane_rdata;   // rdata seen by the lanes
    xlen_t     load_bytes;   // aligned load data

    // no internal stall left
    assign in_ready  = out_ready;
    assign out_valid = st_valid;
    assign out_pc    = st_pc;
    assign out_inst  = st_inst;

    mem_stage_reg u_reg (
        .clk, .rst, .in_valid, .in_pc, .in_inst, .in_op, .in_alu, .in_src2, .out_ready,
        .st_valid, .st_pc, .st_inst, .st_op, .st_alu, .st_src2
    );

    mem_access_ctrl u_ctrl (
        .st_valid, .st_op, .st_alu, .out_ready,
        .acc_size, .acc_off, .acc_signed, .is_load,
        .mem_re, .mem_raddr, .mem_we, .mem_waddr
    );

    // lanes see zero unless a load is in the register
    assign lane_rdata = is_load ? mem_rdata : '0;

    // ********************
    // byte lanes
    // ********************
    for (genvar i = 0; i < `MEM_LANES; i++) begin : g_lane
        mem_byte_lane #(.LANE(i)) u_lane (
            .acc_size,
            .acc_off,
            .store_data (st_src2),
            .read_data  (lane_rdata),
            .wmask_bit  (mem_wmask[i]),
            .wdata_byte (mem_wdata[i*BYTE_W +: BYTE_W]),
            .rdata_byte (load_bytes[i*BYTE_W +: BYTE_W])
        );
    end

    mem_writeback u_wb (
        .st_valid, .st_pc, .st_inst, .st_op, .st_alu, .st_src2,
        .acc_size, .acc_signed, .load_bytes,
        .reg_wr_en, .reg_wr_id, .reg_wr_value
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// free-running 10 ns clock; rst is high for the first three rising edges, then released
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;              // dut still sees rst at the third edge
    end

endmodule

`default_nettype wire

// File: tests/mem_stage_checker.sv
// sampled on the rising edge and quiet while rst is high; bound to mem_stage_top
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      out_valid,
    input logic                      out_ready,
    input mem_stage_pkg::xlen_t      out_pc,
    input logic                      reg_wr_en,
    input logic                      mem_re,
    input logic                      mem_we,
    input mem_stage_pkg::lane_mask_t mem_wmask
);

    // ********************
    // memory port
    // ********************
    a_we_mask: assert property (@(posedge clk) disable iff (rst) mem_we |-> (mem_wmask != '0))
        else $error("memory write strobe with an empty byte mask");
    a_no_rw: assert property (@(posedge clk) disable iff (rst) !(mem_we && mem_re))
        else $error("memory read and write active in the same cycle");

    // ********************
    // downstream
    // ********************
    a_wr_valid: assert property (@(posedge clk) disable iff (rst) reg_wr_en |-> out_valid)
        else $error("register write without a valid item");
    // held item must not move
    a_pc_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> $stable(out_pc))
        else $error("out_pc changed while the item was held");

endmodule

`default_nettype wire

// File: tests/tb_mem_stage.sv
// one item at a time; memory answers combinationally and takes writes on the rising edge
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_consts.svh"

module tb_mem_stage;

    import mem_stage_pkg::*;

    localparam int WAIT_LIMIT = 20;   // cycles before a wait gives up

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    xlen_t      in_pc;
    inst_t      in_inst;
    mem_op_t    in_op;
    xlen_t      in_alu;
    xlen_t      in_src2;
    logic       out_valid;
    logic       out_ready;
    xlen_t      out_pc;
    inst_t      out_inst;
    logic       reg_wr_en;
    reg_id_t    reg_wr_id;
    xlen_t      reg_wr_value;
    logic       mem_re;
    xlen_t      mem_raddr;
    xlen_t      mem_rdata;
    logic       mem_we;
    xlen_t      mem_waddr;
    xlen_t      mem_wdata;
    lane_mask_t mem_wmask;

    xlen_t mem_model [xlen_t];   // keyed by word index
    xlen_t wr_word;
    int    seed;
    int    errors   = 0;
    int    checks   = 0;
    int    we_count = 0;         // write strobes seen
    int    we_start;
    int    err_start;
    int    waits;
    int    stall;
    logic  hung     = 1'b0;
    mem_op_t op;

    tb_clock u_clock (.clk, .rst);

    mem_stage_top dut0 (.*);

    bind mem_stage_top mem_stage_checker u_checker (
        .clk(clk), .rst(rst), .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
        .reg_wr_en(reg_wr_en), .mem_re(mem_re), .mem_we(mem_we), .mem_wmask(mem_wmask)
    );

    // ********************
    // memory model
    // ********************
    function automatic xlen_t read_word(input xlen_t addr);
        xlen_t idx;
        idx = addr >> 3;
        if (mem_model.exists(idx)) begin
            return mem_model[idx];
        end
        return idx * 64'h9e37_79b9_7f4a_7c15;   // untouched words get a fill from the index
    endfunction

    always_comb mem_rdata = read_word(mem_raddr);   // aligned word with no latency

    always @(posedge clk) begin
        if (mem_we) begin
            wr_word = read_word(mem_waddr);
            for (int k = 0; k < `MEM_LANES; k++) begin
                if (mem_wmask[k]) wr_word[k*8 +: 8] = mem_wdata[k*8 +: 8];
            end
            mem_model[mem_waddr >> 3] = wr_word;
            we_count++;
        end
    end

    // ********************
    // random helpers
    // ********************
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int op_bytes(input mem_op_t o);
        case (o)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_LWU, OP_SW: return 4;
            OP_LD, OP_SD:         return 8;
            default:              return 0;   // no access
        endcase
    endfunction

    // naturally aligned within a 16-word window so loads hit earlier stores
    function automatic xlen_t rand_addr(input mem_op_t o);
        int off;
        off = rand_below(8) & ~(op_bytes(o) - 1);
        return 64'h8000_0000 + xlen_t'(rand_below(16) * 8 + off);
    endfunction

    // ********************
    // reference model
    // ********************
    function automatic xlen_t expect_value(input mem_op_t o, input xlen_t pc,
                                           input xlen_t alu, input xlen_t src2);
        xlen_t word;
        xlen_t v;
        int    n;
        int    off;
        n    = op_bytes(o);
        off  = int'(alu[2:0]);
        word = read_word(alu);
        v    = '0;
        case (o)
            OP_ALU:  v = alu;
            OP_LINK: v = pc + xlen_t'(`MEM_PC_STEP);   // return address
            OP_CSR:  v = src2;
            OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU: begin
                for (int j = 0; j < n; j++) begin
                    if (off + j < `MEM_LANES) v[j*8 +: 8] = word[(off + j)*8 +: 8];
                end
                // signed loads copy the top bit upward
                if (!(o inside {OP_LBU, OP_LHU, OP_LWU}) && n < 8 && v[n*8-1]) begin
                    v = v | (~64'h0 << (n*8));
                end
            end
            default: v = '0;   // stores and none
        endcase
        return v;
    endfunction

    // ********************
    // checking
    // ********************
    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_item(input mem_op_t o, input xlen_t pc, input inst_t inst,
                              input xlen_t alu, input xlen_t src2, input xlen_t exp_val);
        logic       st;
        logic       ld;
        int         off;
        int         n;
        xlen_t      keep;
        xlen_t      exp_data;
        lane_mask_t exp_mask;
        st       = o inside {OP_SB, OP_SH, OP_SW, OP_SD};
        ld       = o inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
        off      = int'(alu[2:0]);
        n        = op_bytes(o);
        keep     = '0;
        exp_data = '0;
        exp_mask = '0;
        check_value("out_valid", xlen_t'(out_valid), 64'd1);
        check_value("out_pc", out_pc, pc);
        check_value("out_inst", xlen_t'(out_inst), xlen_t'(inst));
        check_value("reg_wr_en", xlen_t'(reg_wr_en), xlen_t'(o != OP_NONE && !st));
        if (o != OP_NONE && !st) begin
            check_value("reg_wr_id", xlen_t'(reg_wr_id),
                        xlen_t'(inst[`MEM_RD_LSB +: `MEM_REG_ID_W]));
            check_value("reg_wr_value", reg_wr_value, exp_val);
        end
        check_value("mem_re", xlen_t'(mem_re), xlen_t'(ld));
        if (ld) check_value("mem_raddr", mem_raddr, alu);
        check_value("mem_we", xlen_t'(mem_we), xlen_t'(st && out_ready));
        if (st) begin
            for (int j = 0; j < `MEM_LANES; j++) begin
                if (j >= off && j < off + n) begin   // lanes past 7 never appear
                    exp_mask[j]        = 1'b1;
                    keep[j*8 +: 8]     = 8'hff;
                    exp_data[j*8 +: 8] = src2[(j - off)*8 +: 8];
                end
            end
            check_value("mem_waddr", mem_waddr, alu);
            check_value("mem_wmask", xlen_t'(mem_wmask), xlen_t'(exp_mask));
            check_value("mem_wdata", mem_wdata & keep, exp_data);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!in_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            $display("timeout: in_ready stayed low for %0d cycles", WAIT_LIMIT);
            errors++;
            hung = 1'b1;
        end
    endtask

    // one item through the stage, held for stall_cycles with out_ready low
    task automatic send_item(input mem_op_t o, input xlen_t alu, input int stall_cycles);
        xlen_t pc;
        xlen_t src2;
        inst_t inst;
        xlen_t exp_val;
        int    we_before;
        if (hung) return;
        pc      = {$random(seed), $random(seed)};
        inst    = $random(seed);
        src2    = {$random(seed), $random(seed)};
        exp_val = expect_value(o, pc, alu, src2);   // memory is quiet until it leaves
        wait_ready();
        if (hung) return;
        in_valid = 1'b1;
        in_op    = o;
        in_pc    = pc;
        in_inst  = inst;
        in_alu   = alu;
        in_src2  = src2;
        @(negedge clk);                              // taken at the edge just passed
        we_before = we_count;
        check_item(o, pc, inst, alu, src2, exp_val);
        in_valid  = 1'b0;
        out_ready = (stall_cycles == 0);
        for (int c = 0; c < stall_cycles; c++) begin
            @(negedge clk);
            check_value("in_ready", xlen_t'(in_ready), 64'd0);
            check_item(o, pc, inst, alu, src2, exp_val);
            if (c == stall_cycles - 1) out_ready = 1'b1;
        end
        @(negedge clk);                              // item has left
        check_value("mem_we pulses", xlen_t'(we_count - we_before),
                    xlen_t'(o inside {OP_SB, OP_SH, OP_SW, OP_SD}));
    endtask

    task automatic report_test(input string name, input int err_base);
        if (errors == err_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_base);
        end
    endtask

    // ********************
    // test sequence
    // ********************
    initial begin
        seed      = 79;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        in_op     = OP_NONE;
        in_alu    = '0;
        in_src2   = '0;
        out_ready = 1'b1;

        waits = 0;
        while (rst !== 1'b0 && waits < WAIT_LIMIT) begin
            @(negedge clk);
            waits++;
        end
        if (rst !== 1'b0) begin
            $display("timeout: reset was never released");
            errors++;
            hung = 1'b1;
        end

        // idle after reset, then bubbles shaped as a store, an alu op and a load
        err_start = errors;
        check_value("out_valid", xlen_t'(out_valid), 64'd0);
        check_value("reg_wr_en", xlen_t'(reg_wr_en), 64'd0);
        check_value("mem_re", xlen_t'(mem_re), 64'd0);
        check_value("mem_we", xlen_t'(mem_we), 64'd0);
        in_alu   = rand_addr(OP_SD);
        in_src2  = {$random(seed), $random(seed)};
        we_start = we_count;
        for (int b = 0; b < 3; b++) begin
            case (b)
                0:       in_op = OP_SD;
                1:       in_op = OP_ALU;
                default: in_op = OP_LD;
            endcase
            @(negedge clk);
            check_value("bubble reg_wr_en", xlen_t'(reg_wr_en), 64'd0);
            check_value("bubble mem_re", xlen_t'(mem_re), 64'd0);
            check_value("bubble mem_we", xlen_t'(mem_we), 64'd0);
        end
        check_value("bubble writes", xlen_t'(we_count - we_start), 64'd0);
        in_op = OP_NONE;
        report_test("reset and bubble", err_start);

        err_start = errors;
        for (int i = 0; i < 12; i++) begin
            send_item(mem_op_t'(1 + i % 3), {$random(seed), $random(seed)}, 0);
        end
        report_test("alu, link and csr", err_start);

        err_start = errors;
        for (int i = 0; i < 24; i++) begin
            op = mem_op_t'(11 + i % 4);    // sb .. sd in turn
            send_item(op, rand_addr(op), 0);
        end
        report_test("stores", err_start);

        err_start = errors;
        for (int i = 0; i < 24; i++) begin
            op = mem_op_t'(4 + i % 7);     // lb .. lwu in turn
            send_item(op, rand_addr(op), 0);
        end
        report_test("loads", err_start);

        err_start = errors;
        repeat (16) begin
            op    = mem_op_t'(1 + rand_below(14));
            stall = 1 + rand_below(4);
            send_item(op, rand_addr(op), stall);
        end
        report_test("back-pressure", err_start);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
design/mem_stage_pkg.sv
design/mem_stage_reg.sv
design/mem_access_ctrl.sv
design/mem_byte_lane.sv
design/mem_writeback.sv
design/mem_stage_top.sv
tests/tb_clock.sv
tests/mem_stage_checker.sv
tests/tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_stage \
    -f verilog.f \
    -o sim_mem_stage

./obj_dir/sim_mem_stage | tee sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
